/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       ?= tb_io_2to1
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
SIMFLAGS  ?= +verilator+error+limit+100
LOG       ?= sim.log
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Test failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Test ended early"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/io_2to1.sv */
module io_2to1 import ns_pkg::*; (
	input  logic              i_clk,
	input  logic              rst_n,
	input  logic              src0_en,
	input  logic              src1_en,
	input  logic              src0_skip,
	input  logic              src1_skip,
	input  logic              src1_bad,
	output logic              o0_err,
	output logic              o1_err,
	output logic              o_0_err,
	output logic [NS_DSZ-1:0] o_0_ck_dat,
	output logic [NS_DSZ-1:0] fst_err_0_inp,
	output logic [NS_DSZ-1:0] fst_err_0_dat,
	output logic              mrg_req,
	output logic              mrg_ack,
	output logic [NS_ASZ-1:0] mrg_src,
	output logic [NS_DSZ-1:0] mrg_dat
);

	logic              s0_req;
	logic              s0_ack;
	logic [NS_ASZ-1:0] s0_src;
	logic [NS_ASZ-1:0] s0_dst;
	logic [NS_DSZ-1:0] s0_dat;
	logic              s1_req;
	logic              s1_ack;
	logic [NS_ASZ-1:0] s1_src;
	logic [NS_ASZ-1:0] s1_dst;
	logic [NS_DSZ-1:0] s1_dat;

	msg_source u_src0 (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.src_id(NS_ASZ'(0)),
		.en(src0_en),
		.skip(src0_skip),
		// Source 0 has no corrupt strobe
		.bad(1'b0),
		.req(s0_req),
		.ack(s0_ack),
		.src(s0_src),
		.dst(s0_dst),
		.dat(s0_dat)
	);

	msg_source u_src1 (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.src_id(NS_ASZ'(1)),
		.en(src1_en),
		.skip(src1_skip),
		.bad(src1_bad),
		.req(s1_req),
		.ack(s1_ack),
		.src(s1_src),
		.dst(s1_dst),
		.dat(s1_dat)
	);

	// Destination is carried but the sink does not use it
	merge_2to1 u_merge (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.a_req(s0_req),
		.a_ack(s0_ack),
		.a_src(s0_src),
		.a_dst(s0_dst),
		.a_dat(s0_dat),
		.b_req(s1_req),
		.b_ack(s1_ack),
		.b_src(s1_src),
		.b_dst(s1_dst),
		.b_dat(s1_dat),
		.o_req(mrg_req),
		.o_ack(mrg_ack),
		.o_src(mrg_src),
		.o_dst(),
		.o_dat(mrg_dat)
	);

	seq_sink u_sink (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.req(mrg_req),
		.ack(mrg_ack),
		.src(mrg_src),
		.dat(mrg_dat),
		.err_0(o0_err),
		.err_1(o1_err),
		.rng_err(o_0_err),
		.ck_dat(o_0_ck_dat),
		.fst_inp(fst_err_0_inp),
		.fst_dat(fst_err_0_dat)
	);

endmodule

/* hw/merge_2to1.sv */
module merge_2to1 import ns_pkg::*; (
	input  logic              i_clk,
	input  logic              rst_n,
	input  logic              a_req,
	output logic              a_ack,
	input  logic [NS_ASZ-1:0] a_src,
	input  logic [NS_ASZ-1:0] a_dst,
	input  logic [NS_DSZ-1:0] a_dat,
	input  logic              b_req,
	output logic              b_ack,
	input  logic [NS_ASZ-1:0] b_src,
	input  logic [NS_ASZ-1:0] b_dst,
	input  logic [NS_DSZ-1:0] b_dat,
	output logic              o_req,
	input  logic              o_ack,
	output logic [NS_ASZ-1:0] o_src,
	output logic [NS_ASZ-1:0] o_dst,
	output logic [NS_DSZ-1:0] o_dat
);

	logic [NS_MSG_W-1:0]   mem [NS_FIFO_DEPTH];
	logic [NS_FIFO_AW-1:0] wr_ptr;
	logic [NS_FIFO_AW-1:0] rd_ptr;
	logic [NS_FIFO_AW:0]   count;
	logic                  full;
	logic                  empty;
	logic                  last_b;
	logic                  a_new;
	logic                  b_new;
	logic                  take_a;
	logic                  take_b;
	logic                  push;
	logic                  pop;
	ns_msg_u               in_msg;
	ns_msg_u               head;

	assign full = (count == (NS_FIFO_AW+1)'(NS_FIFO_DEPTH));
	assign empty = (count == '0);

	// Fresh request on each input
	assign a_new = a_req && !a_ack;
	assign b_new = b_req && !b_ack;

	// Round robin: on a tie the input not served last wins
	assign take_a = a_new && !full && (!b_new || last_b);
	assign take_b = b_new && !full && !take_a;

	assign push = take_a || take_b;
	assign pop = o_req && o_ack;

	always_comb begin
		if (take_a) begin
			in_msg.fields.src = a_src;
			in_msg.fields.dst = a_dst;
			in_msg.fields.dat = a_dat;
		end else begin
			in_msg.fields.src = b_src;
			in_msg.fields.dst = b_dst;
			in_msg.fields.dat = b_dat;
		end
	end

	// Input side acks and arbitration state
	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			a_ack <= 1'b0;
			b_ack <= 1'b0;
			last_b <= 1'b1;
		end else begin
			if (take_a) begin
				a_ack <= 1'b1;
			end else if (!a_req) begin
				a_ack <= 1'b0;
			end
			if (take_b) begin
				b_ack <= 1'b1;
			end else if (!b_req) begin
				b_ack <= 1'b0;
			end
			if (push) begin
				last_b <= take_b;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (push) begin
			mem[wr_ptr] <= in_msg.raw;
		end
	end

	// Pointers, fill level and output request
	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_req <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (!o_req && !o_ack && !empty) begin
				o_req <= 1'b1;
			end else if (pop) begin
				o_req <= 1'b0;
			end
		end
	end

	// Head entry is held until popped, so fields stay stable under req
	always_comb begin
		head.raw = mem[rd_ptr];
	end

	assign o_src = head.fields.src;
	assign o_dst = head.fields.dst;
	assign o_dat = head.fields.dat;

endmodule

/* hw/msg_source.sv */
module msg_source import ns_pkg::*; (
	input  logic              i_clk,
	input  logic              rst_n,
	input  logic [NS_ASZ-1:0] src_id,
	input  logic              en,
	input  logic              skip,
	input  logic              bad,
	output logic              req,
	input  logic              ack,
	output logic [NS_ASZ-1:0] src,
	output logic [NS_ASZ-1:0] dst,
	output logic [NS_DSZ-1:0] dat
);

	logic [3:0] cnt;
	logic       skip_pend;
	logic       bad_pend;
	logic       skip_any;
	logic       bad_any;
	logic       start;
	logic       done;
	ns_msg_u    msg;

	// Strobes in the start cycle still count for this message
	assign skip_any = skip_pend || skip;
	assign bad_any = bad_pend || bad;

	assign start = !req && !ack && en;
	assign done = req && ack;

	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			req <= 1'b0;
			cnt <= '0;
			skip_pend <= 1'b0;
			bad_pend <= 1'b0;
			msg.fields.dst <= NS_MIN_ADDR;
		end else if (start) begin
			req <= 1'b1;
			cnt <= cnt + (skip_any ? 4'd2 : 4'd1);
			skip_pend <= 1'b0;
			bad_pend <= 1'b0;
			msg.fields.src <= src_id;
			msg.fields.dat <= {{(NS_DSZ-5){1'b0}}, bad_any, cnt};
		end else begin
			if (skip) begin
				skip_pend <= 1'b1;
			end
			if (bad) begin
				bad_pend <= 1'b1;
			end
			if (done) begin
				req <= 1'b0;
				// Rotate destination, wrapping back to the first one
				if (msg.fields.dst >= NS_MAX_ADDR) begin
					msg.fields.dst <= NS_MIN_ADDR;
				end else begin
					msg.fields.dst <= msg.fields.dst + 1'b1;
				end
			end
		end
	end

	assign src = msg.fields.src;
	assign dst = msg.fields.dst;
	assign dat = msg.fields.dat;

endmodule

/* hw/ns_pkg.sv */
package ns_pkg;

	// Channel field widths
	localparam int NS_ASZ = 4;
	localparam int NS_DSZ = 8;
	localparam int NS_MSG_W = NS_ASZ + NS_ASZ + NS_DSZ;

	// Destination rotation range
	localparam logic [NS_ASZ-1:0] NS_MIN_ADDR = NS_ASZ'(1);
	localparam logic [NS_ASZ-1:0] NS_MAX_ADDR = NS_ASZ'(3);

	// Merge buffer
	localparam int NS_FIFO_DEPTH = 4;
	localparam int NS_FIFO_AW = $clog2(NS_FIFO_DEPTH);

	// Sequence check limits
	localparam logic [NS_DSZ-1:0] NS_SEQ_LAST = NS_DSZ'(14);
	localparam logic [NS_DSZ-1:0] NS_CK_INIT = NS_DSZ'(15);

	// One message, flat for storage or split into fields
	typedef union packed {
		logic [NS_MSG_W-1:0] raw;
		struct packed {
			logic [NS_ASZ-1:0] src;
			logic [NS_ASZ-1:0] dst;
			logic [NS_DSZ-1:0] dat;
		} fields;
	} ns_msg_u;

endpackage

/* hw/seq_sink.sv */
module seq_sink import ns_pkg::*; (
	input  logic              i_clk,
	input  logic              rst_n,
	input  logic              req,
	output logic              ack,
	input  logic [NS_ASZ-1:0] src,
	input  logic [NS_DSZ-1:0] dat,
	output logic              err_0,
	output logic              err_1,
	output logic              rng_err,
	output logic [NS_DSZ-1:0] ck_dat,
	output logic [NS_DSZ-1:0] fst_inp,
	output logic [NS_DSZ-1:0] fst_dat
);

	logic [NS_DSZ-1:0] ck_0;
	logic [NS_DSZ-1:0] ck_1;
	logic [NS_DSZ-1:0] ck_sel;
	logic              fst_flg;
	logic              is_0;
	logic              take;
	logic              brk;
	logic              out_rng;

	assign take = req && !ack;
	assign is_0 = (src == '0);
	assign ck_sel = is_0 ? ck_0 : ck_1;

	// Only checked while the last value is not the top of the count
	assign brk = (ck_sel <= NS_SEQ_LAST) && (dat != ck_sel + 1'b1);

	// Counts are 4 bits wide, anything above is out of range
	assign out_rng = |dat[NS_DSZ-1:4];

	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
			ck_0 <= NS_CK_INIT;
			ck_1 <= NS_CK_INIT;
			err_0 <= 1'b0;
			err_1 <= 1'b0;
			rng_err <= 1'b0;
			fst_flg <= 1'b0;
			fst_inp <= '0;
			fst_dat <= '0;
		end else if (take) begin
			ack <= 1'b1;
			if (out_rng) begin
				rng_err <= 1'b1;
			end
			if (brk) begin
				if (is_0) begin
					err_0 <= 1'b1;
				end else begin
					err_1 <= 1'b1;
				end
				// Keep only the first break from either source
				if (!fst_flg) begin
					fst_flg <= 1'b1;
					fst_inp <= dat;
					fst_dat <= ck_sel;
				end
			end else if (is_0) begin
				ck_0 <= dat;
			end else begin
				ck_1 <= dat;
			end
		end else if (!req && ack) begin
			ack <= 1'b0;
		end
	end

	assign ck_dat = ck_0;

endmodule

/* src.f */
hw/ns_pkg.sv
hw/msg_source.sv
hw/merge_2to1.sv
hw/seq_sink.sv
hw/io_2to1.sv
tb/io_2to1_chk.sv
tb/io_2to1_mon.sv
tb/tb_io_2to1.sv

/* tb/io_2to1_chk.sv */
module io_2to1_chk import ns_pkg::*; (
	input logic              i_clk,
	input logic              rst_n,
	input logic              a_req,
	input logic              a_ack,
	input logic              b_req,
	input logic              b_ack,
	input logic              o_req,
	input logic              o_ack,
	input logic [NS_DSZ-1:0] o_dat
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;

	// A request stays up until its ack is seen
	a_req_hold: assert property (@(posedge i_clk) disable iff (!rst_n)
		a_req && !a_ack |=> a_req)
		else begin
			fail_cnt++;
			$error("a_req dropped before a_ack");
		end

	b_req_hold: assert property (@(posedge i_clk) disable iff (!rst_n)
		b_req && !b_ack |=> b_req)
		else begin
			fail_cnt++;
			$error("b_req dropped before b_ack");
		end

	o_req_hold: assert property (@(posedge i_clk) disable iff (!rst_n)
		o_req && !o_ack |=> o_req)
		else begin
			fail_cnt++;
			$error("o_req dropped before o_ack");
		end

	o_dat_stable: assert property (@(posedge i_clk) disable iff (!rst_n)
		o_req |=> !o_req || $stable(o_dat))
		else begin
			fail_cnt++;
			$error("o_dat changed while o_req high");
		end

	// Only one input is taken per cycle
	one_ack: assert property (@(posedge i_clk) disable iff (!rst_n)
		!($rose(a_ack) && $rose(b_ack)))
		else begin
			fail_cnt++;
			$error("a_ack and b_ack rose together");
		end

endmodule

/* tb/io_2to1_mon.sv */
module io_2to1_mon import ns_pkg::*; (
	input  logic              i_clk,
	input  logic              rst_n,
	input  logic              mrg_req,
	input  logic              mrg_ack,
	input  logic [NS_ASZ-1:0] mrg_src,
	input  logic [NS_DSZ-1:0] mrg_dat,
	input  logic              o0_err,
	input  logic              o1_err,
	input  logic              o_0_err,
	input  logic [NS_DSZ-1:0] o_0_ck_dat,
	input  logic [NS_DSZ-1:0] fst_err_0_inp,
	input  logic [NS_DSZ-1:0] fst_err_0_dat,
	output int                err_cnt,
	output int                n_msg_0,
	output int                n_msg_1
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [NS_DSZ-1:0] m_ck_0;
	logic [NS_DSZ-1:0] m_ck_1;
	logic [NS_DSZ-1:0] m_fst_inp;
	logic [NS_DSZ-1:0] m_fst_dat;
	logic              m_err_0;
	logic              m_err_1;
	logic              m_rng;
	logic              m_fst;
	logic              ack_q;

	function automatic int diff(input string name, input logic [NS_DSZ-1:0] exp,
			input logic [NS_DSZ-1:0] got);
		if (got !== exp) begin
			$display("ERR %s exp %h got %h", name, exp, got);
			return 1;
		end
		return 0;
	endfunction

	// Sink outputs settle one cycle after mrg_ack rises, while the entry is still held
	always @(posedge i_clk) begin
		logic [NS_DSZ-1:0] prev;
		int                bad;
		if (!rst_n) begin
			m_ck_0 = NS_CK_INIT;
			m_ck_1 = NS_CK_INIT;
			m_fst_inp = '0;
			m_fst_dat = '0;
			m_err_0 = 1'b0;
			m_err_1 = 1'b0;
			m_rng = 1'b0;
			m_fst = 1'b0;
			ack_q = 1'b0;
		end else begin
			if (mrg_ack && !ack_q) begin
				bad = 0;
				// Request is still up in the cycle after the ack
				if (!mrg_req) begin
					$display("mrg_ack rose while mrg_req was low");
					bad = 1;
				end
				prev = (mrg_src == '0) ? m_ck_0 : m_ck_1;
				if (mrg_dat > 8'd15) begin
					m_rng = 1'b1;
				end
				if (prev <= NS_SEQ_LAST && mrg_dat != prev + 8'd1) begin
					if (mrg_src == '0) begin
						m_err_0 = 1'b1;
					end else begin
						m_err_1 = 1'b1;
					end
					if (!m_fst) begin
						m_fst = 1'b1;
						m_fst_inp = mrg_dat;
						m_fst_dat = prev;
					end
				end else if (mrg_src == '0) begin
					m_ck_0 = mrg_dat;
				end else begin
					m_ck_1 = mrg_dat;
				end

				bad += diff("o0_err", NS_DSZ'(m_err_0), NS_DSZ'(o0_err));
				bad += diff("o1_err", NS_DSZ'(m_err_1), NS_DSZ'(o1_err));
				bad += diff("o_0_err", NS_DSZ'(m_rng), NS_DSZ'(o_0_err));
				bad += diff("o_0_ck_dat", m_ck_0, o_0_ck_dat);
				bad += diff("fst_err_0_inp", m_fst_inp, fst_err_0_inp);
				bad += diff("fst_err_0_dat", m_fst_dat, fst_err_0_dat);
				err_cnt <= err_cnt + bad;
				if (mrg_src == '0) begin
					n_msg_0 <= n_msg_0 + 1;
				end else begin
					n_msg_1 <= n_msg_1 + 1;
				end
			end
			ack_q = mrg_ack;
		end
	end

endmodule

/* tb/tb_io_2to1.sv */
module tb_io_2to1 import ns_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ROWS = 12;
	localparam int RST_CYC = 2;
	localparam int MARGIN = 200;

	logic              i_clk = 1'b0;
	logic              rst_n;
	logic              src0_en;
	logic              src1_en;
	logic              src0_skip;
	logic              src1_skip;
	logic              src1_bad;
	logic              o0_err;
	logic              o1_err;
	logic              o_0_err;
	logic [NS_DSZ-1:0] o_0_ck_dat;
	logic [NS_DSZ-1:0] fst_err_0_inp;
	logic [NS_DSZ-1:0] fst_err_0_dat;
	logic              mrg_req;
	logic              mrg_ack;
	logic [NS_ASZ-1:0] mrg_src;
	logic [NS_DSZ-1:0] mrg_dat;

	int tb_err = 0;
	int mon_err;
	int n_msg_0;
	int n_msg_1;
	int cyc_cnt = 0;
	int limit;

	// Stimulus table, en is {src1, src0}, faults are {bad1, skip1, skip0}
	// Flag columns are {o0_err, o1_err, o_0_err}, mask selects the checked ones
	int         row_cyc [N_ROWS];
	logic       row_rnd [N_ROWS];
	logic [1:0] row_en [N_ROWS];
	logic [2:0] row_flt [N_ROWS];
	logic [2:0] row_mask [N_ROWS];
	logic [2:0] row_exp [N_ROWS];

	always #2 i_clk = ~i_clk;

	io_2to1 u_dut (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.src0_en(src0_en),
		.src1_en(src1_en),
		.src0_skip(src0_skip),
		.src1_skip(src1_skip),
		.src1_bad(src1_bad),
		.o0_err(o0_err),
		.o1_err(o1_err),
		.o_0_err(o_0_err),
		.o_0_ck_dat(o_0_ck_dat),
		.fst_err_0_inp(fst_err_0_inp),
		.fst_err_0_dat(fst_err_0_dat),
		.mrg_req(mrg_req),
		.mrg_ack(mrg_ack),
		.mrg_src(mrg_src),
		.mrg_dat(mrg_dat)
	);

	io_2to1_mon u_mon (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.mrg_req(mrg_req),
		.mrg_ack(mrg_ack),
		.mrg_src(mrg_src),
		.mrg_dat(mrg_dat),
		.o0_err(o0_err),
		.o1_err(o1_err),
		.o_0_err(o_0_err),
		.o_0_ck_dat(o_0_ck_dat),
		.fst_err_0_inp(fst_err_0_inp),
		.fst_err_0_dat(fst_err_0_dat),
		.err_cnt(mon_err),
		.n_msg_0(n_msg_0),
		.n_msg_1(n_msg_1)
	);

	bind merge_2to1 io_2to1_chk u_chk (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.a_req(a_req),
		.a_ack(a_ack),
		.b_req(b_req),
		.b_ack(b_ack),
		.o_req(o_req),
		.o_ack(o_ack),
		.o_dat(o_dat)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic add_row(input int r, input int cyc, input logic rnd, input logic [1:0] en,
			input logic [2:0] flt, input logic [2:0] mask, input logic [2:0] exp);
		row_cyc[r] = cyc;
		row_rnd[r] = rnd;
		row_en[r] = en;
		row_flt[r] = flt;
		row_mask[r] = mask;
		row_exp[r] = exp;
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERR %s exp %h got %h", name, exp, got);
			tb_err++;
		end
	endtask

	task automatic check_byte(input string name, input logic [NS_DSZ-1:0] exp,
			input logic [NS_DSZ-1:0] got);
		if (got !== exp) begin
			$display("ERR %s exp %h got %h", name, exp, got);
			tb_err++;
		end
	endtask

	task automatic report_counts();
		$display("Errors: table %0d, monitor %0d, assertions %0d", tb_err, mon_err,
			u_dut.u_merge.u_chk.fail_cnt);
	endtask

	// Run limit from the table length plus a margin
	always @(posedge i_clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			tb_err++;
			report_counts();
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		logic [31:0] rng;
		int          n0_q;
		int          n1_q;
		int          total;
		add_row(0, 200, 1'b0, 2'b11, 3'b000, 3'b111, 3'b000);
		add_row(1, 160, 1'b1, 2'b11, 3'b000, 3'b111, 3'b000);
		add_row(2, 100, 1'b0, 2'b01, 3'b000, 3'b111, 3'b000);
		add_row(3, 100, 1'b0, 2'b10, 3'b000, 3'b111, 3'b000);
		add_row(4, 60, 1'b0, 2'b00, 3'b000, 3'b111, 3'b000);
		add_row(5, 120, 1'b0, 2'b11, 3'b000, 3'b111, 3'b000);
		// Each skip is pulsed twice, a jump right after 15 is not a break
		add_row(6, 48, 1'b0, 2'b11, 3'b001, 3'b011, 3'b000);
		add_row(7, 80, 1'b0, 2'b11, 3'b001, 3'b111, 3'b100);
		add_row(8, 48, 1'b0, 2'b11, 3'b010, 3'b101, 3'b100);
		add_row(9, 80, 1'b0, 2'b11, 3'b010, 3'b111, 3'b110);
		add_row(10, 80, 1'b0, 2'b11, 3'b100, 3'b111, 3'b111);
		add_row(11, 120, 1'b1, 2'b11, 3'b000, 3'b111, 3'b111);
		limit = RST_CYC + 1 + MARGIN;
		for (int r = 0; r < N_ROWS; r++) begin
			limit += row_cyc[r];
		end

		rst_n = 1'b0;
		src0_en = 1'b0;
		src1_en = 1'b0;
		src0_skip = 1'b0;
		src1_skip = 1'b0;
		src1_bad = 1'b0;
		rng = 32'd55236;
		repeat (RST_CYC) @(posedge i_clk);
		rst_n <= 1'b1;
		@(posedge i_clk);
		check_bit("o0_err", 1'b0, o0_err);
		check_bit("o1_err", 1'b0, o1_err);
		check_bit("o_0_err", 1'b0, o_0_err);
		check_byte("o_0_ck_dat", NS_CK_INIT, o_0_ck_dat);

		for (int r = 0; r < N_ROWS; r++) begin
			n0_q = n_msg_0;
			n1_q = n_msg_1;
			src0_en <= row_en[r][0];
			src1_en <= row_en[r][1];
			src0_skip <= row_flt[r][0];
			src1_skip <= row_flt[r][1];
			src1_bad <= row_flt[r][2];
			@(posedge i_clk);
			src0_skip <= 1'b0;
			src1_skip <= 1'b0;
			src1_bad <= 1'b0;
			for (int c = 1; c < row_cyc[r]; c++) begin
				if (row_rnd[r] && (c % 8 == 0)) begin
					rng = xorshift(rng);
					src0_en <= rng[0];
					src1_en <= rng[1];
				end
				@(posedge i_clk);
			end

			if (row_mask[r][2]) begin
				check_bit("o0_err", row_exp[r][2], o0_err);
			end
			if (row_mask[r][1]) begin
				check_bit("o1_err", row_exp[r][1], o1_err);
			end
			if (row_mask[r][0]) begin
				check_bit("o_0_err", row_exp[r][0], o_0_err);
			end

			if (!row_rnd[r] && row_en[r][0] && n_msg_0 == n0_q) begin
				$display("Source 0 delivered no message in row %0d", r);
				tb_err++;
			end
			if (!row_rnd[r] && row_en[r][1] && n_msg_1 == n1_q) begin
				$display("Source 1 delivered no message in row %0d", r);
				tb_err++;
			end
			// Both sources off, the merged channel has to drain
			if (!row_rnd[r] && row_en[r] == 2'b00) begin
				check_bit("mrg_req", 1'b0, mrg_req);
				check_bit("mrg_ack", 1'b0, mrg_ack);
			end
			if (r == 0 && (n_msg_0 < 17 || n_msg_1 < 17)) begin
				$display("Too few messages in row 0 to see the count wrap");
				tb_err++;
			end
		end

		total = tb_err + mon_err + u_dut.u_merge.u_chk.fail_cnt;
		report_counts();
		if (total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
